// File: build.f
neuron_pkg.sv
fp32_adder.sv
frame_collector.sv
adder_tree.sv
neuron_accumulator.sv
tb_result_checker.sv
tb_neuron_accumulator.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_neuron_accumulator
FILELIST   = build.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_neuron_accumulator.sv
`timescale 1ns/100ps

module tb_neuron_accumulator;

	localparam int N_INPUTS  = 32;
	localparam int LATENCY   = 43;
	localparam int NUM_ROWS  = 9;
	localparam int MODE_ONES  = 0; // Every operand 1.0
	localparam int MODE_ZEROS = 1;
	localparam int MODE_PAIRS = 2; // +x then -x
	localparam int MODE_LCG   = 3;

	typedef struct packed {
		int mode;
		int bias_h; // Bias in units of 0.5
		int gap;    // Idle cycles after each word
	} row_t;

	row_t rows [NUM_ROWS] = '{
		'{MODE_ONES,  1,    0},
		'{MODE_PAIRS, 0,    0},
		'{MODE_ZEROS, -6,   0},
		'{MODE_LCG,   7,    0},
		'{MODE_LCG,   -3,   2},
		'{MODE_LCG,   2045, 1},
		'{MODE_ONES,  0,    3},
		'{MODE_LCG,   100,  0},
		'{MODE_PAIRS, -2,   1}
	};

	logic        clk;
	logic        rst_n;
	logic        i_valid;
	logic [31:0] i_data;
	logic        o_valid;
	logic [31:0] o_data;
	logic [31:0] lcg_state;
	int          mismatches;
	int          failures;
	int          results;
	int          pending;
	int          cycles;
	int          timeout_limit;

	function automatic int next_random_halves();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[31:16] % 16'd4093) - 2046; // -1023.0 to +1023.0
	endfunction

	function automatic logic [31:0] halves_to_word(input int h);
		logic [31:0] mag;
		int          msb;
		logic        sgn;
		if (h == 0) begin
			return 32'd0;
		end
		sgn = (h < 0);
		mag = sgn ? 32'(-h) : 32'(h);
		msb = 0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				msb = i;
			end
		end
		return {sgn, 8'(126 + msb), 23'(mag << (23 - msb))}; // Halves shift exponent by one
	endfunction

	task automatic print_error_counts(input int extra);
		$display("Errors: %0d mismatch, %0d other", mismatches, failures + extra);
	endtask

	neuron_accumulator #(
		.N_INPUTS (N_INPUTS)
	) dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	tb_result_checker #(
		.N_INPUTS (N_INPUTS),
		.LATENCY  (LATENCY)
	) checker_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_in_valid   (i_valid),
		.i_in_data    (i_data),
		.i_out_valid  (o_valid),
		.i_out_data   (o_data),
		.o_mismatches (mismatches),
		.o_failures   (failures),
		.o_results    (results),
		.o_pending    (pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles >= timeout_limit) begin
				$display("TIMEOUT: %0d expected results still missing after %0d cycles",
					pending, cycles);
				print_error_counts(1);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	initial begin
		logic [31:0] word;
		int          pair_h;
		int          h;
		rst_n     = 1'b0;
		i_valid   = 1'b0;
		i_data    = 32'd0;
		lcg_state = 32'ha86c;
		cycles    = 0;
		pair_h    = 0;
		timeout_limit = LATENCY + 100;
		for (int r = 0; r < NUM_ROWS; r++) begin
			timeout_limit += (N_INPUTS + 1) * (1 + rows[r].gap);
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int w = 0; w <= N_INPUTS; w++) begin
				case (rows[r].mode)
					MODE_ONES:  h = 2;
					MODE_ZEROS: h = 0;
					MODE_PAIRS: begin
						if (w % 2 == 0) begin
							pair_h = next_random_halves();
						end
						h = (w % 2 == 0) ? pair_h : -pair_h;
					end
					default:    h = next_random_halves();
				endcase
				word = (w == N_INPUTS) ? halves_to_word(rows[r].bias_h) : halves_to_word(h);
				@(posedge clk);
				i_valid <= 1'b1;
				i_data  <= word;
				repeat (rows[r].gap) begin
					@(posedge clk);
					i_valid <= 1'b0;
				end
			end
		end
		@(posedge clk);
		i_valid <= 1'b0;

		while (results < NUM_ROWS) begin
			@(posedge clk);
		end
		repeat (LATENCY + 10) @(posedge clk); // Room for any extra pulse to show up

		print_error_counts(0);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tb_result_checker.sv
`timescale 1ns/100ps

module tb_result_checker #(
	parameter int N_INPUTS = 32,
	parameter int LATENCY  = 43
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_in_valid,
	input  logic [31:0] i_in_data,
	input  logic        i_out_valid,
	input  logic [31:0] i_out_data,
	output int          o_mismatches,
	output int          o_failures,
	output int          o_results,
	output int          o_pending
);

	logic [31:0] exp_q [$];      // Expected words in frame order
	int          bias_cyc_q [$]; // Cycle that accepted each bias
	real         acc;            // Running frame sum
	int          word_idx;       // Position inside the current frame
	int          cyc;

	// Subnormals read as zero, like the adder input stage
	function automatic real word_to_real(input logic [31:0] w);
		real r;
		int  e;
		if (w[30:23] == 8'd0) begin
			return 0.0;
		end
		r = 1.0 + real'(w[22:0]) / 8388608.0;
		e = int'(w[30:23]) - 127;
		while (e > 0) begin
			r = r * 2.0;
			e--;
		end
		while (e < 0) begin
			r = r / 2.0;
			e++;
		end
		return w[31] ? -r : r;
	endfunction

	// Only exact values reach here, so no rounding is needed
	function automatic logic [31:0] real_to_word(input real v);
		real  a;
		int   e;
		logic sgn;
		if (v == 0.0) begin
			return 32'd0; // Exact cancellation gives +0
		end
		sgn = (v < 0.0);
		a   = sgn ? -v : v;
		e   = 127;
		while (a >= 2.0) begin
			a = a / 2.0;
			e++;
		end
		while (a < 1.0) begin
			a = a * 2.0;
			e--;
		end
		return {sgn, 8'(e), 23'($rtoi((a - 1.0) * 8388608.0))};
	endfunction

	always @(posedge clk or negedge rst_n) begin
		logic [31:0] expected;
		int          bias_cyc;
		if (!rst_n) begin
			acc          = 0.0;
			word_idx     = 0;
			cyc          = 0;
			exp_q.delete();
			bias_cyc_q.delete();
			o_mismatches <= 0;
			o_failures   <= 0;
			o_results    <= 0;
			o_pending    <= 0;
		end else begin
			cyc = cyc + 1;
			if (i_in_valid) begin
				acc = acc + word_to_real(i_in_data);
				if (word_idx == N_INPUTS) begin // Bias word closes the frame
					exp_q.push_back(real_to_word(acc));
					bias_cyc_q.push_back(cyc);
					acc      = 0.0;
					word_idx = 0;
				end else begin
					word_idx++;
				end
			end
			if (i_out_valid) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: o_valid pulsed with no frame waiting for it", $time);
					o_failures <= o_failures + 1;
				end else begin
					expected = exp_q.pop_front();
					bias_cyc = bias_cyc_q.pop_front();
					o_results <= o_results + 1;
					if (i_out_data !== expected) begin
						$display("MISMATCH at %0t: o_data got %h expected %h",
							$time, i_out_data, expected);
						o_mismatches <= o_mismatches + 1;
					end
					if (cyc - bias_cyc != LATENCY) begin
						$display("ERROR at %0t: result came %0d cycles after its bias, not %0d",
							$time, cyc - bias_cyc, LATENCY);
						o_failures <= o_failures + 1;
					end
				end
			end
			o_pending <= exp_q.size();
		end
	end

endmodule

// File: neuron_accumulator.sv
`timescale 1ns/100ps

module neuron_accumulator #(
	parameter int N_INPUTS = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  neuron_pkg::fp32_t i_data,
	output logic              o_valid,
	output neuron_pkg::fp32_t o_data
);
	import neuron_pkg::*;

	logic  vec_valid;
	fp32_t vec [N_INPUTS]; // Operands of one frame
	fp32_t bias;

	frame_collector #(
		.N_INPUTS (N_INPUTS)
	) u_collector (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_valid     (i_valid),
		.i_data      (i_data),
		.o_vec_valid (vec_valid),
		.o_vec       (vec),
		.o_bias      (bias)
	);

	adder_tree #(
		.N_INPUTS (N_INPUTS)
	) u_tree (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (vec_valid),
		.i_vec   (vec),
		.i_bias  (bias),
		.o_valid (o_valid),
		.o_sum   (o_data)
	);

endmodule

// File: adder_tree.sv
`timescale 1ns/100ps

module adder_tree #(
	parameter int N_INPUTS = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  neuron_pkg::fp32_t i_vec [N_INPUTS],
	input  neuron_pkg::fp32_t i_bias,
	output logic              o_valid,
	output neuron_pkg::fp32_t o_sum
);
	import neuron_pkg::*;

	localparam int LEVELS     = $clog2(N_INPUTS);
	localparam int BIAS_DEPTH = ADD_LATENCY * LEVELS; // Matches the tree root
	localparam int N_NODES    = 2 * N_INPUTS - 1;

	// Heap order with node k fed by nodes 2k+1 and 2k+2
	fp32_t node_sum [N_NODES];
	logic  node_vld [N_NODES];
	fp32_t bias_dly [BIAS_DEPTH];

	genvar k;
	generate
		for (k = 0; k < N_INPUTS; k++) begin : g_leaf
			assign node_sum[N_INPUTS-1+k] = i_vec[k]; // Leaves in input order
			assign node_vld[N_INPUTS-1+k] = i_valid;
		end

		for (k = 0; k < N_INPUTS - 1; k++) begin : g_node
			fp32_adder u_add (
				.clk     (clk),
				.rst_n   (rst_n),
				.i_valid (node_vld[2*k+1] & node_vld[2*k+2]),
				.i_a     (node_sum[2*k+1]),
				.i_b     (node_sum[2*k+2]),
				.o_valid (node_vld[k]),
				.o_sum   (node_sum[k])
			);
		end
	endgenerate

	// Free running so overlapping frames keep their own bias
	always_ff @(posedge clk) begin
		bias_dly[0] <= i_bias;
		for (int i = 1; i < BIAS_DEPTH; i++) begin
			bias_dly[i] <= bias_dly[i-1];
		end
	end

	fp32_adder u_bias_add (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (node_vld[0]),
		.i_a     (node_sum[0]),
		.i_b     (bias_dly[BIAS_DEPTH-1]),
		.o_valid (o_valid),
		.o_sum   (o_sum)
	);

endmodule

// File: frame_collector.sv
`timescale 1ns/100ps

module frame_collector #(
	parameter int N_INPUTS = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  neuron_pkg::fp32_t i_data,
	output logic              o_vec_valid,
	output neuron_pkg::fp32_t o_vec [N_INPUTS],
	output neuron_pkg::fp32_t o_bias
);
	import neuron_pkg::*;

	localparam int CNT_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1;

	collect_state_t   state;
	logic [CNT_W-1:0] word_cnt; // Next operand slot
	fp32_t            op_buf [N_INPUTS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= COLLECT_DATA;
			word_cnt    <= '0;
			o_vec_valid <= 1'b0;
		end else begin
			o_vec_valid <= 1'b0;
			if (i_valid) begin
				case (state)
					COLLECT_DATA: begin
						if (word_cnt == CNT_W'(N_INPUTS - 1)) begin
							word_cnt <= '0;
							state    <= COLLECT_BIAS; // Next word is the bias
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
					COLLECT_BIAS: begin
						state       <= COLLECT_DATA;
						o_vec_valid <= 1'b1;
					end
					default: begin
						state <= COLLECT_DATA;
					end
				endcase
			end
		end
	end

	// Second register stage frees op_buf for the next frame
	always_ff @(posedge clk) begin
		if (i_valid && state == COLLECT_DATA) begin
			op_buf[word_cnt] <= i_data;
		end
		if (i_valid && state == COLLECT_BIAS) begin
			o_vec  <= op_buf;
			o_bias <= i_data;
		end
	end

endmodule

// File: fp32_adder.sv
`timescale 1ns/100ps

module fp32_adder (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_valid,
	input  neuron_pkg::fp32_t i_a,
	input  neuron_pkg::fp32_t i_b,
	output logic              o_valid,
	output neuron_pkg::fp32_t o_sum
);
	import neuron_pkg::*;

	logic [6:0]  vld_q;     // Valid bit per stage
	add_case_t   cls_q [6]; // Class of stages 1 to 6
	fp32_t       byp_q [6]; // Result used when an operand is zero

	logic        a_zero;
	logic        b_zero;
	add_case_t   cls_d;
	fp32_t       byp_d;

	logic        s1_sign_a;
	logic        s1_sign_b;
	logic [7:0]  s1_exp_a;
	logic [7:0]  s1_exp_b;
	logic [23:0] s1_man_a;
	logic [23:0] s1_man_b;

	logic        a_larger;
	logic        s2_sign;
	logic        s2_sub;
	logic [7:0]  s2_exp;
	logic [7:0]  s2_shift;
	logic [23:0] s2_man_l;
	logic [23:0] s2_man_s;

	logic [4:0]  shamt;
	logic [53:0] shifted;
	logic [26:0] aligned;
	logic        s3_sign;
	logic        s3_sub;
	logic [7:0]  s3_exp;
	logic [26:0] s3_man_l;
	logic [26:0] s3_man_s;

	logic [27:0] sum_d;
	logic        s4_sign;
	logic [7:0]  s4_exp;
	logic [27:0] s4_sum;

	logic        s5_sign;
	logic [7:0]  s5_exp;
	logic [27:0] s5_sum;
	logic [4:0]  s5_lz;

	logic [26:0] norm_man;
	logic [9:0]  norm_exp;
	logic        s6_sign;
	logic [9:0]  s6_exp;  // Two's complement, may underflow
	logic [26:0] s6_man;  // Hidden bit at 26, guard round sticky at 2..0

	logic        round_up;
	logic [24:0] mant_r;
	logic [9:0]  exp_r;
	fp32_t       norm_word;
	fp32_t       sum_word;

	// Leading zeros of the 28 bit raw sum
	function automatic logic [4:0] lzc28(input logic [27:0] v);
		logic [4:0] n;
		n = 5'd27;
		for (int i = 0; i < 28; i++) begin
			if (v[i]) begin
				n = 5'(27 - i);
			end
		end
		return n;
	endfunction

	always_comb begin
		a_zero = (i_a.exponent == 8'd0); // Subnormals flush to zero
		b_zero = (i_b.exponent == 8'd0);
		if (a_zero) begin
			cls_d = ADD_ZERO_A;
			byp_d = b_zero ? fp32_t'({i_a.sign & i_b.sign, 31'd0}) : i_b;
		end else begin
			cls_d = b_zero ? ADD_ZERO_B : ADD_NORMAL;
			byp_d = i_a;
		end
	end

	assign a_larger = {s1_exp_a, s1_man_a} >= {s1_exp_b, s1_man_b};

	always_comb begin
		shamt   = (s2_shift > 8'd27) ? 5'd27 : s2_shift[4:0];
		shifted = {s2_man_s, 3'b000, 27'd0} >> shamt;
		aligned = {shifted[53:28], shifted[27] | (|shifted[26:0])}; // Sticky into lsb
	end

	always_comb begin
		if (s3_sub) begin
			sum_d = {1'b0, s3_man_l} - {1'b0, s3_man_s}; // Never negative after swap
		end else begin
			sum_d = {1'b0, s3_man_l} + {1'b0, s3_man_s};
		end
	end

	always_comb begin
		if (s5_lz == 5'd0) begin
			norm_man = {s5_sum[27:2], s5_sum[1] | s5_sum[0]}; // Carry out
			norm_exp = {2'b00, s5_exp} + 10'd1;
		end else begin
			norm_man = s5_sum[26:0] << (s5_lz - 5'd1);
			norm_exp = {2'b00, s5_exp} - 10'(s5_lz) + 10'd1;
		end
	end

	always_comb begin
		round_up = s6_man[2] & (s6_man[1] | s6_man[0] | s6_man[3]); // Ties to even
		mant_r   = {1'b0, s6_man[26:3]} + 25'(round_up);
		exp_r    = s6_exp + 10'(mant_r[24]);
		if (exp_r[9] || exp_r == 10'd0) begin
			norm_word = {s6_sign, 31'd0};
		end else if (exp_r >= 10'd255) begin
			norm_word = {s6_sign, 8'hff, 23'd0}; // Saturated exponent
		end else begin
			norm_word = {s6_sign, exp_r[7:0], mant_r[24] ? mant_r[23:1] : mant_r[22:0]};
		end
		case (cls_q[5])
			ADD_ZERO_A, ADD_ZERO_B: sum_word = byp_q[5];
			ADD_CANCEL:             sum_word = '0;
			default:                sum_word = norm_word;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
			for (int i = 0; i < 6; i++) begin
				cls_q[i] <= ADD_NORMAL;
			end
		end else begin
			vld_q    <= {vld_q[5:0], i_valid};
			cls_q[0] <= cls_d;
			cls_q[1] <= cls_q[0];
			cls_q[2] <= cls_q[1];
			cls_q[3] <= (cls_q[2] == ADD_NORMAL && sum_d == 28'd0) ? ADD_CANCEL : cls_q[2];
			cls_q[4] <= cls_q[3];
			cls_q[5] <= cls_q[4];
		end
	end

	always_ff @(posedge clk) begin
		s1_sign_a <= i_a.sign;
		s1_sign_b <= i_b.sign;
		s1_exp_a  <= i_a.exponent;
		s1_exp_b  <= i_b.exponent;
		s1_man_a  <= {1'b1, i_a.mantissa};
		s1_man_b  <= {1'b1, i_b.mantissa};
		byp_q[0]  <= byp_d;
		for (int i = 1; i < 6; i++) begin
			byp_q[i] <= byp_q[i-1];
		end

		s2_sign  <= a_larger ? s1_sign_a : s1_sign_b; // Larger magnitude first
		s2_sub   <= s1_sign_a ^ s1_sign_b;
		s2_exp   <= a_larger ? s1_exp_a : s1_exp_b;
		s2_shift <= a_larger ? s1_exp_a - s1_exp_b : s1_exp_b - s1_exp_a;
		s2_man_l <= a_larger ? s1_man_a : s1_man_b;
		s2_man_s <= a_larger ? s1_man_b : s1_man_a;

		s3_sign  <= s2_sign;
		s3_sub   <= s2_sub;
		s3_exp   <= s2_exp;
		s3_man_l <= {s2_man_l, 3'b000};
		s3_man_s <= aligned;

		s4_sign <= s3_sign;
		s4_exp  <= s3_exp;
		s4_sum  <= sum_d;

		s5_sign <= s4_sign;
		s5_exp  <= s4_exp;
		s5_sum  <= s4_sum;
		s5_lz   <= lzc28(s4_sum);

		s6_sign <= s5_sign;
		s6_exp  <= norm_exp;
		s6_man  <= norm_man;

		o_sum <= sum_word;
	end

	assign o_valid = vld_q[6];

endmodule

// File: neuron_pkg.sv
package neuron_pkg;

	// IEEE-754 single precision word
	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} fp32_t;

	localparam int ADD_LATENCY = 7; // Input edge to output strobe of fp32_adder

	typedef enum logic {
		COLLECT_DATA,
		COLLECT_BIAS
	} collect_state_t;

	// Special cases carried down the adder pipeline
	typedef enum logic [1:0] {
		ADD_NORMAL,
		ADD_ZERO_A,
		ADD_ZERO_B,
		ADD_CANCEL
	} add_case_t;

endpackage
